/* verilog/sifhPkg.sv */
`default_nettype none

package sifhPkg;

    localparam int TS_WIDTH      = 12;
    localparam int BIN_BITS      = 6;
    localparam int BIN_NUM       = 64;
    localparam int COUNT_WIDTH   = 16; // counts saturate at all ones
    localparam int PHOTON_WIDTH  = 16;

    localparam int WB_ADDR_WIDTH = 3;
    localparam int WB_DATA_WIDTH = 32;

    localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL    = 3'd0; // bit 0 starts a run
    localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS  = 3'd1; // bit 0 busy, bit 1 done
    localparam logic [WB_ADDR_WIDTH-1:0] REG_PHOTONS = 3'd2;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_COARSE  = 3'd3;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_FINE    = 3'd4;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_CLEAR  = 3'd1,
        ST_BUILD  = 3'd2,
        ST_SCAN   = 3'd3,
        ST_WINDOW = 3'd4
    } sifhState;

endpackage

`default_nettype wire

/* verilog/histRam.sv */
`timescale 1ns/10ps
`default_nettype none

module histRam import sifhPkg::*; (
    input  wire                   clk,
    input  wire                   we,
    input  wire [BIN_BITS-1:0]    waddr,
    input  wire [COUNT_WIDTH-1:0] wdata,
    input  wire [BIN_BITS-1:0]    raddr,
    output logic [COUNT_WIDTH-1:0] rdata
);

    logic [COUNT_WIDTH-1:0] mem [BIN_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // same-address read returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* verilog/histBuilder.sv */
`timescale 1ns/10ps
`default_nettype none

module histBuilder import sifhPkg::*; (
    input  wire                     clk,
    input  wire                     res,
    input  wire                     buildEn,
    input  wire                     binMode,   // 0 coarse, 1 fine
    input  wire [TS_WIDTH-1:0]      winLow,
    input  wire [PHOTON_WIDTH-1:0]  remaining,
    input  wire [TS_WIDTH-1:0]      ts,
    input  wire                     tsValid,
    input  wire [COUNT_WIDTH-1:0]   ramRdata,
    output logic                    tsReady,
    output logic                    accepted,
    output logic                    idle,
    output logic [BIN_BITS-1:0]     bWaddr,
    output logic [COUNT_WIDTH-1:0]  bWdata,
    output logic                    bWe,
    output logic [BIN_BITS-1:0]     bRaddr
);

    logic [TS_WIDTH-1:0]    winHigh;
    logic                   inWindow;
    logic                   take;
    logic                   countIt;
    logic [BIN_BITS-1:0]    bin;
    logic                   s1Valid;   // item waiting for its read data
    logic [BIN_BITS-1:0]    s1Bin;
    logic                   fwdValid;  // write issued last cycle
    logic [BIN_BITS-1:0]    fwdBin;
    logic [COUNT_WIDTH-1:0] fwdData;
    logic [COUNT_WIDTH-1:0] base;

    assign tsReady  = buildEn && (remaining != '0);
    assign take     = tsValid && tsReady;
    assign accepted = take; // dropped timestamps count too

    assign winHigh  = winLow + TS_WIDTH'(BIN_NUM - 1);
    assign inWindow = (ts >= winLow) && (ts <= winHigh);
    assign bin      = binMode ? ts[BIN_BITS-1:0] : ts[TS_WIDTH-1:TS_WIDTH-BIN_BITS];
    assign countIt  = take && (!binMode || inWindow);

    assign bRaddr = bin; // read in the transfer cycle

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid  <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s1Valid  <= countIt;
            fwdValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= bin;
        fwdBin  <= s1Bin;
        fwdData <= bWdata;
    end

    // the RAM missed last cycle's write to this bin
    assign base   = (fwdValid && (fwdBin == s1Bin)) ? fwdData : ramRdata;
    assign bWdata = (base == '1) ? base : base + 1'b1; // saturate
    assign bWaddr = s1Bin;
    assign bWe    = s1Valid;

    assign idle = !s1Valid && !fwdValid;

endmodule

`default_nettype wire

/* verilog/peakFinder.sv */
`timescale 1ns/10ps
`default_nettype none

module peakFinder import sifhPkg::*; (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    scanStart,
    input  wire [COUNT_WIDTH-1:0]  ramRdata,
    output logic [BIN_BITS-1:0]    fRaddr,
    output logic                   scanDone,
    output logic [BIN_BITS-1:0]    peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount
);

    logic                active;
    logic                rdValid; // ramRdata belongs to rdBin
    logic [BIN_BITS-1:0] rdBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active   <= 1'b0;
            rdValid  <= 1'b0;
            fRaddr   <= '0;
            scanDone <= 1'b0;
        end else begin
            rdValid  <= active;
            scanDone <= 1'b0;
            if (scanStart) begin
                active <= 1'b1;
                fRaddr <= '0;
            end else if (active) begin
                fRaddr <= fRaddr + 1'b1;
                if (fRaddr == BIN_BITS'(BIN_NUM - 1)) begin
                    active <= 1'b0;
                end
            end
            if (rdValid && (rdBin == BIN_BITS'(BIN_NUM - 1))) begin
                scanDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdBin <= fRaddr;
        if (scanStart) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (rdValid && (ramRdata > peakCount)) begin // ties keep lower bin
            peakBin   <= rdBin;
            peakCount <= ramRdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/wbRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module wbRegs import sifhPkg::*; (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      cyc,
    input  wire                      stb,
    input  wire                      we,
    input  wire [WB_ADDR_WIDTH-1:0]  adr,
    input  wire [WB_DATA_WIDTH-1:0]  datWr,
    input  wire                      busy,
    input  wire                      done,
    input  wire [BIN_BITS-1:0]       coarseBin,
    input  wire [COUNT_WIDTH-1:0]    coarseCount,
    input  wire [TS_WIDTH-1:0]       fineTs,
    input  wire [COUNT_WIDTH-1:0]    fineCount,
    output logic [WB_DATA_WIDTH-1:0] datRd,
    output logic                     ack,
    output logic                     start,
    output logic [PHOTON_WIDTH-1:0]  photons
);

    logic req;

    assign req = cyc && stb && !ack; // one ack per request

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ack     <= 1'b0;
            start   <= 1'b0;
            photons <= '0;
        end else begin
            ack   <= req;
            start <= req && we && (adr == REG_CTRL) && datWr[0];
            if (req && we && (adr == REG_PHOTONS)) begin
                photons <= datWr[PHOTON_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !we) begin
            case (adr)
                REG_STATUS:  datRd <= {30'd0, done, busy};
                REG_PHOTONS: datRd <= {16'd0, photons};
                REG_COARSE:  datRd <= {coarseCount, 10'd0, coarseBin};
                REG_FINE:    datRd <= {fineCount, 4'd0, fineTs};
                default:     datRd <= '0; // control reg reads back zero
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/sifhControl.sv */
`timescale 1ns/10ps
`default_nettype none

module sifhControl import sifhPkg::*; (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      start,
    input  wire [PHOTON_WIDTH-1:0]   photons,
    input  wire                      accepted,
    input  wire                      builderIdle,
    input  wire                      scanDone,
    input  wire [BIN_BITS-1:0]       peakBin,
    input  wire [COUNT_WIDTH-1:0]    peakCount,
    input  wire [BIN_BITS-1:0]       bWaddr,
    input  wire [COUNT_WIDTH-1:0]    bWdata,
    input  wire                      bWe,
    input  wire [BIN_BITS-1:0]       bRaddr,
    input  wire [BIN_BITS-1:0]       fRaddr,
    output logic                     busy,
    output logic                     done,
    output logic                     buildEn,
    output logic                     binMode,
    output logic [TS_WIDTH-1:0]      winLow,
    output logic [PHOTON_WIDTH-1:0]  remaining,
    output logic                     scanStart,
    output logic [BIN_BITS-1:0]      ramWaddr,
    output logic [COUNT_WIDTH-1:0]   ramWdata,
    output logic                     ramWe,
    output logic [BIN_BITS-1:0]      ramRaddr,
    output logic [BIN_BITS-1:0]      coarseBin,
    output logic [COUNT_WIDTH-1:0]   coarseCount,
    output logic [TS_WIDTH-1:0]      fineTs,
    output logic [COUNT_WIDTH-1:0]   fineCount
);

    sifhState            state;
    logic                pass;    // 0 coarse, 1 fine
    logic [BIN_BITS-1:0] clrAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= ST_IDLE;
            pass      <= 1'b0;
            clrAddr   <= '0;
            remaining <= '0;
            winLow    <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin // only seen here, so ignored while busy
                        busy    <= 1'b1;
                        done    <= 1'b0;
                        pass    <= 1'b0;
                        clrAddr <= '0;
                        state   <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == BIN_BITS'(BIN_NUM - 1)) begin
                        remaining <= photons;
                        state     <= ST_BUILD;
                    end
                end
                ST_BUILD: begin
                    if (accepted) begin
                        remaining <= remaining - 1'b1;
                    end
                    // all taken and the builder pipeline has drained
                    if ((remaining == '0) && builderIdle) begin
                        scanStart <= 1'b1;
                        state     <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (scanDone) begin
                        if (pass) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_WINDOW;
                        end
                    end
                end
                ST_WINDOW: begin
                    winLow  <= {coarseBin, {BIN_BITS{1'b0}}}; // coarse bin times 64
                    pass    <= 1'b1;
                    clrAddr <= '0;
                    state   <= ST_CLEAR;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_SCAN) && scanDone) begin
            if (pass) begin
                fineTs    <= winLow + TS_WIDTH'(peakBin);
                fineCount <= peakCount;
            end else begin
                coarseBin   <= peakBin;
                coarseCount <= peakCount;
            end
        end
    end

    assign buildEn = (state == ST_BUILD);
    assign binMode = pass;

    // memory ownership follows the phase
    always_comb begin
        ramWe    = 1'b0;
        ramWaddr = bWaddr;
        ramWdata = bWdata;
        ramRaddr = bRaddr;
        case (state)
            ST_CLEAR: begin
                ramWe    = 1'b1;
                ramWaddr = clrAddr;
                ramWdata = '0;
            end
            ST_BUILD: ramWe = bWe;
            ST_SCAN:  ramRaddr = fRaddr;
            default:  ramWe = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sifhTop.sv */
`timescale 1ns/10ps
`default_nettype none

module sifhTop import sifhPkg::*; (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      cyc,
    input  wire                      stb,
    input  wire                      we,
    input  wire [WB_ADDR_WIDTH-1:0]  adr,
    input  wire [WB_DATA_WIDTH-1:0]  datWr,
    input  wire [TS_WIDTH-1:0]       ts,
    input  wire                      tsValid,
    output logic [WB_DATA_WIDTH-1:0] datRd,
    output logic                     ack,
    output logic                     tsReady
);

    logic                    start;
    logic [PHOTON_WIDTH-1:0] photons;
    logic                    busy;
    logic                    done;
    logic [BIN_BITS-1:0]     coarseBin;
    logic [COUNT_WIDTH-1:0]  coarseCount;
    logic [TS_WIDTH-1:0]     fineTs;
    logic [COUNT_WIDTH-1:0]  fineCount;

    logic                    buildEn;
    logic                    binMode;
    logic [TS_WIDTH-1:0]     winLow;
    logic [PHOTON_WIDTH-1:0] remaining;
    logic                    accepted;
    logic                    builderIdle;
    logic [BIN_BITS-1:0]     bWaddr;
    logic [COUNT_WIDTH-1:0]  bWdata;
    logic                    bWe;
    logic [BIN_BITS-1:0]     bRaddr;

    logic                    scanStart;
    logic                    scanDone;
    logic [BIN_BITS-1:0]     fRaddr;
    logic [BIN_BITS-1:0]     peakBin;
    logic [COUNT_WIDTH-1:0]  peakCount;

    logic [BIN_BITS-1:0]     ramWaddr;
    logic [COUNT_WIDTH-1:0]  ramWdata;
    logic                    ramWe;
    logic [BIN_BITS-1:0]     ramRaddr;
    logic [COUNT_WIDTH-1:0]  ramRdata;

    wbRegs regsInst (
        .clk(clk), .res(res), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .busy(busy), .done(done), .coarseBin(coarseBin), .coarseCount(coarseCount),
        .fineTs(fineTs), .fineCount(fineCount),
        .datRd(datRd), .ack(ack), .start(start), .photons(photons)
    );

    sifhControl ctrlInst (
        .clk(clk), .res(res), .start(start), .photons(photons),
        .accepted(accepted), .builderIdle(builderIdle), .scanDone(scanDone),
        .peakBin(peakBin), .peakCount(peakCount),
        .bWaddr(bWaddr), .bWdata(bWdata), .bWe(bWe), .bRaddr(bRaddr), .fRaddr(fRaddr),
        .busy(busy), .done(done), .buildEn(buildEn), .binMode(binMode),
        .winLow(winLow), .remaining(remaining), .scanStart(scanStart),
        .ramWaddr(ramWaddr), .ramWdata(ramWdata), .ramWe(ramWe), .ramRaddr(ramRaddr),
        .coarseBin(coarseBin), .coarseCount(coarseCount),
        .fineTs(fineTs), .fineCount(fineCount)
    );

    histBuilder builderInst (
        .clk(clk), .res(res), .buildEn(buildEn), .binMode(binMode), .winLow(winLow),
        .remaining(remaining), .ts(ts), .tsValid(tsValid), .ramRdata(ramRdata),
        .tsReady(tsReady), .accepted(accepted), .idle(builderIdle),
        .bWaddr(bWaddr), .bWdata(bWdata), .bWe(bWe), .bRaddr(bRaddr)
    );

    peakFinder finderInst (
        .clk(clk), .res(res), .scanStart(scanStart), .ramRdata(ramRdata),
        .fRaddr(fRaddr), .scanDone(scanDone), .peakBin(peakBin), .peakCount(peakCount)
    );

    histRam ramInst (
        .clk(clk), .we(ramWe), .waddr(ramWaddr), .wdata(ramWdata),
        .raddr(ramRaddr), .rdata(ramRdata)
    );

endmodule

`default_nettype wire

/* testbench/sifhChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module sifhChecker import sifhPkg::*; (
    input  wire                     clk,
    input  wire                     cyc,
    input  wire                     stb,
    input  wire                     we,
    input  wire [WB_ADDR_WIDTH-1:0] adr,
    input  wire [WB_DATA_WIDTH-1:0] datRd,
    input  wire                     ack,
    input  wire                     tsValid,
    input  wire                     tsReady,
    input  wire [1:0]               runState,
    input  wire [PHOTON_WIDTH-1:0]  expN,
    input  wire [BIN_BITS-1:0]      expCoarseBin,
    input  wire [COUNT_WIDTH-1:0]   expCoarseCount,
    input  wire [TS_WIDTH-1:0]      expFineTs,
    input  wire [COUNT_WIDTH-1:0]   expFineCount,
    output int                      errCount
);

    localparam int PASS_GAP = 2 + (BIN_NUM + 2) + 1 + BIN_NUM; // drain, scan, window, clear

    int                       errors   = 0;
    int                       accCount = 0; // timestamps taken in this run
    int                       quiet    = 0; // cycles since pass 1 ended
    bit                       pending  = 1'b0;
    bit                       reqPrev  = 1'b0;
    bit                       reqWe    = 1'b0;
    logic [WB_ADDR_WIDTH-1:0] reqAdr   = '0;
    logic [1:0]               runPrev  = 2'd0;

    assign errCount = errors;

    task automatic compareRead(input logic [WB_ADDR_WIDTH-1:0] a,
                               input logic [WB_DATA_WIDTH-1:0] d);
        logic [WB_DATA_WIDTH-1:0] expVal;
        bit ok;
        string name;
        case (a)
            REG_STATUS: begin
                name   = "REG_STATUS";
                expVal = (runState == 2'd0) ? 32'd0 : (runState == 2'd1) ? 32'd1 : 32'd2;
                ok     = (d == expVal) || (runState == 2'd2 && d == 32'd1); // busy while polling
            end
            REG_PHOTONS: begin
                name   = "REG_PHOTONS";
                expVal = {16'd0, expN};
                ok     = (d == expVal);
            end
            REG_COARSE: begin
                name   = "REG_COARSE";
                expVal = {expCoarseCount, 10'd0, expCoarseBin};
                ok     = (runState != 2'd3) || (d == expVal);
            end
            REG_FINE: begin
                name   = "REG_FINE";
                expVal = {expFineCount, 4'd0, expFineTs};
                ok     = (runState != 2'd3) || (d == expVal);
            end
            default: begin
                name   = "unused register";
                expVal = '0;
                ok     = (d == expVal);
            end
        endcase
        if (!ok) begin
            errors++;
            $display("Mismatch at %0t: %s read 0x%08h, expected 0x%08h", $time, name, d, expVal);
        end
    endtask

    // inputs settle 1 ns after the rising edge, so the falling edge sees stable values
    always @(negedge clk) begin
        if (cyc && stb && !reqPrev) begin
            if (pending) begin
                errors++;
                $display("Error at %0t: a new Wishbone request started before its ack", $time);
            end
            pending = 1'b1;
            reqAdr  = adr;
            reqWe   = we;
        end
        reqPrev = cyc && stb;
        if (ack) begin
            if (!pending) begin
                errors++;
                $display("Error at %0t: ack came without a pending request", $time);
            end else if (!reqWe) begin
                compareRead(reqAdr, datRd);
            end
            pending = 1'b0;
        end

        if (runState == 2'd1 && runPrev != 2'd1) begin
            accCount = 0;
            quiet    = 0;
        end
        if (runState == 2'd1 || runState == 2'd2) begin
            if (tsReady && accCount >= 2 * int'(expN)) begin
                errors++;
                $display("Error at %0t: tsReady is high after the last timestamp", $time);
            end else if (tsReady && accCount == int'(expN) && quiet < PASS_GAP) begin
                errors++;
                $display("Error at %0t: tsReady is high right after pass 1 ended", $time);
            end
            if (accCount == int'(expN)) quiet++;
            if (tsValid && tsReady) accCount++;
        end
        if (runState == 2'd3 && runPrev != 2'd3 && accCount != 2 * int'(expN)) begin
            errors++;
            $display("Mismatch at %0t: %0d timestamps accepted, expected %0d",
                     $time, accCount, 2 * int'(expN));
        end
        runPrev = runState;
    end

endmodule

`default_nettype wire

/* testbench/sifhTb.sv */
`timescale 1ns/10ps
`default_nettype none

module sifhTb import sifhPkg::*; ();

    localparam int ACK_TIMEOUT   = 16;
    localparam int READY_TIMEOUT = 1000; // covers drain, scan, window and clear between passes
    localparam int DONE_POLLS    = 400;

    logic                     clk;
    logic                     res;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    logic [WB_DATA_WIDTH-1:0] datWr;
    logic [TS_WIDTH-1:0]      ts;
    logic                     tsValid;
    wire  [WB_DATA_WIDTH-1:0] datRd;
    wire                      ack;
    wire                      tsReady;

    logic [1:0]               runState; // 0 none, 1 started, 2 running, 3 finished
    logic [PHOTON_WIDTH-1:0]  expN;
    logic [BIN_BITS-1:0]      expCoarseBin;
    logic [COUNT_WIDTH-1:0]   expCoarseCount;
    logic [TS_WIDTH-1:0]      expFineTs;
    logic [COUNT_WIDTH-1:0]   expFineCount;
    int                       checkErrors;
    int                       tbErrors;
    bit                       aborted;
    int unsigned              seed;
    int                       fd;
    logic [TS_WIDTH-1:0]      stamps[$]; // pass 1 then pass 2

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    sifhTop dut_i (
        .clk(clk), .res(res), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .ts(ts), .tsValid(tsValid), .datRd(datRd), .ack(ack), .tsReady(tsReady)
    );

    sifhChecker checkInst (
        .clk(clk), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datRd(datRd), .ack(ack),
        .tsValid(tsValid), .tsReady(tsReady), .runState(runState), .expN(expN),
        .expCoarseBin(expCoarseBin), .expCoarseCount(expCoarseCount),
        .expFineTs(expFineTs), .expFineCount(expFineCount), .errCount(checkErrors)
    );

    function automatic int unsigned nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    task automatic reportTimeout(input string what);
        $display("Timeout at %0t: timeout waiting for %s", $time, what);
        tbErrors++;
        aborted = 1'b1;
    endtask

    task automatic wbAccess(input logic write, input logic [WB_ADDR_WIDTH-1:0] addr,
                            input logic [WB_DATA_WIDTH-1:0] data,
                            output logic [WB_DATA_WIDTH-1:0] rdata);
        int waited;
        bit acked;
        rdata = '0;
        if (!aborted) begin
            cyc    = 1'b1;
            stb    = 1'b1;
            we     = write;
            adr    = addr;
            datWr  = data;
            waited = 0;
            acked  = 1'b0;
            while (!acked && waited < ACK_TIMEOUT) begin
                @(posedge clk);
                #1;
                if (ack) acked = 1'b1;
                else waited++;
            end
            rdata = datRd;
            cyc   = 1'b0;
            stb   = 1'b0;
            we    = 1'b0;
            @(posedge clk); // one idle cycle between accesses
            #1;
            if (!acked) reportTimeout("Wishbone ack");
        end
    endtask

    task automatic sendTs(input logic [TS_WIDTH-1:0] value);
        int unsigned r;
        int gap;
        int waited;
        bit taken;
        r   = nextRand();
        gap = (r % 3 == 0) ? int'((r >> 4) % 2) + 1 : 0; // about a third get a gap
        tsValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        ts      = value;
        tsValid = 1'b1;
        waited  = 0;
        taken   = 1'b0;
        while (!taken && waited < READY_TIMEOUT) begin
            @(negedge clk);
            if (tsReady) taken = 1'b1; // transfer on the coming edge
            else waited++;
        end
        @(posedge clk);
        #1;
        tsValid = 1'b0;
        if (!taken) reportTimeout("tsReady");
    endtask

    // skips comment and blank lines
    task automatic nextLine(output string line, output bit found);
        int r;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r") found = 1'b1;
        end
    endtask

    task automatic loadTest(output bit got);
        string line;
        bit found;
        int r;
        int unsigned n, cb, cc, ft, fc;
        logic [TS_WIDTH-1:0] value;
        got = 1'b0;
        stamps.delete();
        nextLine(line, found);
        if (found) begin
            r = $sscanf(line, "%h %h %h %h %h", n, cb, cc, ft, fc);
            if (r != 5) begin
                $display("Error: a header line in the test file has fewer than five fields");
                tbErrors++;
                aborted = 1'b1;
            end else begin
                expN           = PHOTON_WIDTH'(n);
                expCoarseBin   = BIN_BITS'(cb);
                expCoarseCount = COUNT_WIDTH'(cc);
                expFineTs      = TS_WIDTH'(ft);
                expFineCount   = COUNT_WIDTH'(fc);
                got = 1'b1;
                for (int i = 0; i < 2 * int'(n) && got; i++) begin
                    nextLine(line, found);
                    r = found ? $sscanf(line, "%h", value) : 0;
                    if (r != 1) begin
                        $display("Error: the test file ends before all timestamps are read");
                        tbErrors++;
                        aborted = 1'b1;
                        got = 1'b0;
                    end else begin
                        stamps.push_back(value);
                    end
                end
            end
        end
    endtask

    task automatic runTest();
        logic [WB_DATA_WIDTH-1:0] rd;
        bit doneSeen;
        int polls;
        wbAccess(1'b1, REG_PHOTONS, WB_DATA_WIDTH'(expN), rd);
        wbAccess(1'b0, REG_PHOTONS, '0, rd); // readback
        wbAccess(1'b1, REG_CTRL, 32'd1, rd);
        runState = 2'd1;
        wbAccess(1'b0, REG_STATUS, '0, rd); // must show busy
        runState = 2'd2;
        foreach (stamps[i]) begin
            if (!aborted) sendTs(stamps[i]);
        end
        doneSeen = 1'b0;
        polls    = 0;
        while (!doneSeen && !aborted && polls < DONE_POLLS) begin
            wbAccess(1'b0, REG_STATUS, '0, rd);
            doneSeen = rd[1];
            polls++;
        end
        if (!doneSeen && !aborted) reportTimeout("done");
        runState = 2'd3;
        wbAccess(1'b0, REG_COARSE, '0, rd);
        wbAccess(1'b0, REG_FINE, '0, rd);
        wbAccess(1'b0, REG_STATUS, '0, rd);
    endtask

    initial begin : mainFlow
        logic [WB_DATA_WIDTH-1:0] rd;
        bit got;
        int tests;
        res            = 1'b0;
        cyc            = 1'b0;
        stb            = 1'b0;
        we             = 1'b0;
        adr            = '0;
        datWr          = '0;
        ts             = '0;
        tsValid        = 1'b0;
        runState       = 2'd0;
        expN           = '0;
        expCoarseBin   = '0;
        expCoarseCount = '0;
        expFineTs      = '0;
        expFineCount   = '0;
        seed           = 81;
        tbErrors       = 0;
        aborted        = 1'b0;
        tests          = 0;
        repeat (2) @(posedge clk);
        #1;
        res = 1'b1;
        fd = $fopen("testbench/sifhTests.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open testbench/sifhTests.txt");
            tbErrors++;
        end else begin
            wbAccess(1'b0, 3'd5, '0, rd); // unused address reads zero
            got = 1'b1;
            while (got && !aborted) begin
                loadTest(got);
                if (got) begin
                    tests++;
                    runTest();
                end
            end
            $fclose(fd);
            if (tests == 0 && !aborted) begin
                $display("Error: the test file holds no test case");
                tbErrors++;
            end
        end
        $display("Errors: checker %0d, testbench %0d", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sifhTests.txt */
# header: photons coarseBin coarseCount fineTs fineCount, all hex
# then 2*photons timestamp lines in hex, pass 1 first, then pass 2
6 0e 3 391 2
385
3a0
3bf
812
3c0
100
391
3a2
391
791
791
3a2
5 03 4 0c7 4
0c7
0c7
0c7
0c7
fff
0c7
0c7
0c7
0c7
0c1
4 08 2 23f 2
7c0
200
7ff
23f
23f
200
23f
240

/* project.f */
verilog/sifhPkg.sv
verilog/histRam.sv
verilog/histBuilder.sv
verilog/peakFinder.sv
verilog/wbRegs.sv
verilog/sifhControl.sv
verilog/sifhTop.sv
testbench/sifhChecker.sv
testbench/sifhTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module sifhTb -f project.f -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
